/* compile.f */
+incdir+include
logic/isa_pkg.sv
logic/sb_pkg.sv
logic/window_ptrs.sv
logic/stage_tracker.sv
logic/reg_state.sv
logic/fu_stations.sv
logic/entry_store.sv
logic/sb_top.sv
dv/sb_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0 -Wno-fatal
TOP       = sb_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* dv/sb_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sb_cfg.svh"

module sb_tb
    import isa_pkg::*, sb_pkg::*;
();

    localparam int N_TOTAL = 10 + 8 + 5 + 6 + 12 + 300;
    localparam int TIMEOUT = N_TOTAL * (`SB_MUL_CYCLES + `SB_DEPTH) * 2 + 100;

    logic    clk;
    logic    resetn;
    logic    in_valid;
    instr_t  in_instr;
    logic    stall;
    logic    commit_valid;
    commit_t commit;

    word_t   model_rf [`SB_NREG];
    commit_t exp_q [$];
    int      cycles;
    logic    saw_stall;

    sb_top dut0 (
        .clk(clk), .resetn(resetn), .in_valid(in_valid), .in_instr(in_instr),
        .stall(stall), .commit_valid(commit_valid), .commit(commit)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic instr_t make_instr(input op_e op, input int rd, input int rs1,
                                          input int rs2, input int imm);
        instr_t i;
        i.op  = op;
        i.rd  = reg_idx_t'(rd);
        i.rs1 = reg_idx_t'(rs1);
        i.rs2 = reg_idx_t'(rs2);
        i.imm = imm[`SB_IMM_W-1:0];
        return i;
    endfunction

    // executes in program order on the model register file
    function automatic commit_t model_exec(input instr_t i);
        word_t a;
        word_t b;
        word_t imm_ext;
        word_t res;
        a = model_rf[i.rs1];
        b = model_rf[i.rs2];
        imm_ext = {{(`SB_XLEN - `SB_IMM_W){i.imm[`SB_IMM_W-1]}}, i.imm};
        case (i.op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_XOR:  res = a ^ b;
            OP_ADDI: res = a + imm_ext;
            default: res = a * b;
        endcase
        if (i.rd != '0) begin
            model_rf[i.rd] = res;
        end
        return '{rd: i.rd, data: res};
    endfunction

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_commit(input commit_t got, input commit_t exp);
        if (got !== exp) begin
            $display("Fail %0t commit got rd=%0d data=%h expected rd=%0d data=%h",
                     $time, got.rd, got.data, exp.rd, exp.data);
            stop_with_error("committed record differs from the model");
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %0t %s got %b expected %b", $time, name, got, exp);
            stop_with_error("level check failed");
        end
    endtask

    // holds the instruction until a cycle without stall takes it
    task automatic send_instr(input instr_t i);
        logic took;
        in_valid = 1'b1;
        in_instr = i;
        do begin
            took = !stall;
            if (took) begin
                exp_q.push_back(model_exec(i));
            end
            @(posedge clk);
            #2;
        end while (!took);
        in_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic drain_window();
        do begin
            @(posedge clk);
        end while (exp_q.size() != 0);
        #2;
    endtask

    task automatic run_addi_stream();
        for (int k = 1; k <= 10; k++) begin
            send_instr(make_instr(OP_ADDI, k, 0, 0, (k % 3 == 0) ? -100 * k : 3 * k + 1));
        end
        drain_window();
    endtask

    task automatic run_raw_chain();
        op_e ops [4];
        ops = '{OP_ADD, OP_SUB, OP_XOR, OP_ADDI};
        for (int k = 0; k < 8; k++) begin
            send_instr(make_instr(ops[k % 4], 12 + k, 11 + k, 1 + k, 17 * k - 9));
        end
        drain_window();
    endtask

    // ALU ops finish ahead of the multiply but commit behind it
    task automatic run_mul_overlap();
        send_instr(make_instr(OP_MUL, 20, 1, 2, 0));
        send_instr(make_instr(OP_ADD, 21, 3, 4, 0));
        send_instr(make_instr(OP_SUB, 22, 5, 6, 0));
        send_instr(make_instr(OP_XOR, 23, 7, 8, 0));
        send_instr(make_instr(OP_ADDI, 24, 9, 0, -100));
        drain_window();
    endtask

    task automatic run_war_waw();
        send_instr(make_instr(OP_MUL, 25, 3, 4, 0));
        send_instr(make_instr(OP_ADDI, 3, 0, 0, 77));
        send_instr(make_instr(OP_ADD, 26, 3, 4, 0));
        send_instr(make_instr(OP_ADDI, 26, 1, 0, 9));
        send_instr(make_instr(OP_MUL, 25, 25, 2, 0));
        send_instr(make_instr(OP_XOR, 27, 25, 26, 0));
        drain_window();
    endtask

    task automatic run_mul_stall();
        saw_stall = 1'b0;
        send_instr(make_instr(OP_MUL, 28, 1, 2, 0));
        for (int k = 0; k < 11; k++) begin
            send_instr(make_instr(OP_MUL, 28, 28, 3, 0));
        end
        drain_window();
        if (!saw_stall) begin
            stop_with_error("stall never rose while the multiply chain filled the window");
        end
        check_level("stall", stall, 1'b0);
    endtask

    task automatic run_random_mix(input int n);
        instr_t i;
        for (int k = 0; k < n; k++) begin
            i = make_instr(op_e'($urandom_range(4)), $urandom_range(7), $urandom_range(7),
                           $urandom_range(7), $urandom_range(4095));
            send_instr(i);
            if ($urandom_range(3) == 0) begin
                idle_cycles(1);
            end
        end
        drain_window();
    endtask

    // each commit is matched against the oldest expected record
    always @(negedge clk) begin
        if (resetn) begin
            if (stall) begin
                saw_stall = 1'b1;
            end
            if (commit_valid) begin
                if (exp_q.size() == 0) begin
                    stop_with_error("commit seen with no instruction outstanding");
                end else begin
                    check_commit(commit, exp_q.pop_front());
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            stop_with_error("timeout, the DUT did not commit all instructions in time");
        end
    end

    initial begin
        void'($urandom(32'ha077));
        resetn    = 1'b0;
        in_valid  = 1'b0;
        in_instr  = '0;
        saw_stall = 1'b0;
        cycles    = 0;
        for (int r = 0; r < `SB_NREG; r++) begin
            model_rf[r] = '0;
        end
        repeat (2) @(posedge clk);
        #2;
        resetn = 1'b1;
        check_level("stall", stall, 1'b0);
        check_level("commit_valid", commit_valid, 1'b0);

        run_addi_stream();
        run_raw_chain();
        run_mul_overlap();
        run_war_waw();
        run_mul_stall();
        run_random_mix(300);
        // a stray late commit would show up here
        idle_cycles(20);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/sb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sb_top
    import isa_pkg::*, sb_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,
    input  logic    in_valid,
    input  instr_t  in_instr,
    output logic    stall,
    output logic    commit_valid,
    output commit_t commit
);

    logic         accept;
    entry_idx_t   wptr;
    entry_idx_t   dptr;
    entry_idx_t   rptr;
    instr_t       head_instr;
    dispatch_t    dispatch;
    logic [1:0]   fu_busy;
    issue_t [1:0] issue_entry;
    wb_t          wb;
    fu_tag_e      rs1_tag;
    fu_tag_e      rs2_tag;
    fu_tag_e      rd_pending;
    word_t        rdata1;
    word_t        rdata2;
    reg_idx_t     rd1_idx;
    reg_idx_t     rd2_idx;
    commit_t      wb_record;

    assign wb_record = '{rd: wb.rd, data: wb.data};

    window_ptrs ptrs0 (
        .clk(clk), .resetn(resetn), .in_valid(in_valid),
        .dispatch_fire(dispatch.valid), .retire_fire(commit_valid),
        .accept(accept), .wptr(wptr), .dptr(dptr), .rptr(rptr), .stall(stall)
    );

    entry_store #(.payload_t(instr_t)) instr_store0 (
        .clk(clk), .we(accept), .waddr(wptr), .wdata(in_instr),
        .raddr(dptr), .rdata(head_instr)
    );

    stage_tracker tracker0 (
        .clk(clk), .resetn(resetn), .accept(accept),
        .wptr(wptr), .dptr(dptr), .rptr(rptr), .head_instr(head_instr),
        .fu_busy(fu_busy), .rd_pending(rd_pending), .issue_entry(issue_entry),
        .wb(wb), .dispatch(dispatch), .retire(commit_valid)
    );

    reg_state regs0 (
        .clk(clk), .resetn(resetn), .head_instr(head_instr), .dispatch(dispatch),
        .wb(wb), .rd1_idx(rd1_idx), .rd2_idx(rd2_idx),
        .rs1_tag(rs1_tag), .rs2_tag(rs2_tag), .rd_pending(rd_pending),
        .rdata1(rdata1), .rdata2(rdata2)
    );

    fu_stations fu0 (
        .clk(clk), .resetn(resetn), .dispatch(dispatch),
        .rs1_tag(rs1_tag), .rs2_tag(rs2_tag), .rdata1(rdata1), .rdata2(rdata2),
        .fu_busy(fu_busy), .issue_entry(issue_entry), .wb(wb),
        .rd1_idx(rd1_idx), .rd2_idx(rd2_idx)
    );

    // results wait here until their entry reaches the retire pointer
    entry_store #(.payload_t(commit_t)) result_store0 (
        .clk(clk), .we(wb.valid), .waddr(wb.idx), .wdata(wb_record),
        .raddr(rptr), .rdata(commit)
    );

endmodule

`default_nettype wire

/* logic/entry_store.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sb_cfg.svh"

module entry_store
    import sb_pkg::*;
#(
    parameter type payload_t = logic
) (
    input  logic       clk,
    input  logic       we,
    input  entry_idx_t waddr,
    input  payload_t   wdata,
    input  entry_idx_t raddr,
    output payload_t   rdata
);

    payload_t mem [`SB_DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    assign rdata = mem[raddr];

endmodule

`default_nettype wire

/* logic/fu_stations.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sb_cfg.svh"

module fu_stations
    import isa_pkg::*, sb_pkg::*;
(
    input  logic         clk,
    input  logic         resetn,
    input  dispatch_t    dispatch,
    input  fu_tag_e      rs1_tag,
    input  fu_tag_e      rs2_tag,
    input  word_t        rdata1,
    input  word_t        rdata2,
    output logic [1:0]   fu_busy,
    output issue_t [1:0] issue_entry,
    output wb_t          wb,
    output reg_idx_t     rd1_idx,
    output reg_idx_t     rd2_idx
);

    localparam int TW = $clog2(`SB_MUL_CYCLES + 1);

    typedef struct packed {
        logic                 busy;
        logic                 issued;
        entry_idx_t           idx;
        op_e                  op;
        reg_idx_t             rd;
        reg_idx_t             rs1;
        reg_idx_t             rs2;
        logic                 use2;
        fu_tag_e              t1;
        fu_tag_e              t2;
        logic [`SB_IMM_W-1:0] imm;
        word_t                result;
    } station_t;

    // station 0 is the ALU, station 1 the multiplier
    station_t      stn [2];
    logic [TW-1:0] mul_timer;
    logic [1:0]    ready;
    logic [1:0]    finished;
    logic [1:0]    war_hold;
    logic [1:0]    issue_go;
    logic [1:0]    wb_go;
    logic          iss_sel;
    logic          wb_sel;
    logic          disp_unit;
    word_t         exec_result;

    // a tag whose writer broadcasts this cycle is already resolved
    function automatic fu_tag_e live_tag(input fu_tag_e t, input wb_t w);
        return (w.valid && w.tag == t) ? FU_NONE : t;
    endfunction

    always_comb begin
        for (int u = 0; u < 2; u++) begin
            ready[u] = stn[u].busy && !stn[u].issued &&
                       stn[u].t1 == FU_NONE && stn[u].t2 == FU_NONE;
            finished[u] = stn[u].busy && stn[u].issued && (u == 0 || mul_timer == '0);
            // WAR: an older reader of rd has not issued yet
            war_hold[u] = 1'b0;
            for (int v = 0; v < 2; v++) begin
                if (v != u && stn[v].busy && !stn[v].issued && stn[u].rd != '0) begin
                    if (stn[v].rs1 == stn[u].rd && stn[v].t1 != unit_tag(1'(u))) begin
                        war_hold[u] = 1'b1;
                    end
                    if (stn[v].use2 && stn[v].rs2 == stn[u].rd &&
                        stn[v].t2 != unit_tag(1'(u))) begin
                        war_hold[u] = 1'b1;
                    end
                end
            end
            issue_entry[u].valid = issue_go[u];
            issue_entry[u].idx   = stn[u].idx;
            fu_busy[u]           = stn[u].busy;
        end
    end

    // one pair of read ports, the ALU goes first
    assign issue_go[0] = ready[0];
    assign issue_go[1] = ready[1] && !ready[0];
    assign iss_sel     = !ready[0];
    assign rd1_idx     = stn[iss_sel].rs1;
    assign rd2_idx     = stn[iss_sel].rs2;

    always_comb begin
        case (stn[iss_sel].op)
            OP_SUB:  exec_result = rdata1 - rdata2;
            OP_XOR:  exec_result = rdata1 ^ rdata2;
            OP_ADDI: exec_result = rdata1 + word_t'($signed(stn[iss_sel].imm));
            OP_MUL:  exec_result = rdata1 * rdata2;
            default: exec_result = rdata1 + rdata2;
        endcase
    end

    assign wb_go[0] = finished[0] && !war_hold[0];
    assign wb_go[1] = finished[1] && !war_hold[1] && !wb_go[0];
    assign wb_sel   = !wb_go[0];

    always_comb begin
        wb.valid = |wb_go;
        wb.tag   = unit_tag(wb_sel);
        wb.idx   = stn[wb_sel].idx;
        wb.rd    = stn[wb_sel].rd;
        wb.data  = stn[wb_sel].result;
    end

    assign disp_unit = fu_of(dispatch.instr.op);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int u = 0; u < 2; u++) begin
                stn[u].busy   <= 1'b0;
                stn[u].issued <= 1'b0;
                stn[u].t1     <= FU_NONE;
                stn[u].t2     <= FU_NONE;
            end
            mul_timer <= '0;
        end else begin
            for (int u = 0; u < 2; u++) begin
                stn[u].t1 <= live_tag(stn[u].t1, wb);
                stn[u].t2 <= live_tag(stn[u].t2, wb);
                if (issue_go[u]) begin
                    stn[u].issued <= 1'b1;
                    stn[u].result <= exec_result;
                end
                if (wb_go[u]) begin
                    stn[u].busy <= 1'b0;
                end
                if (dispatch.valid && disp_unit == 1'(u)) begin
                    stn[u].busy   <= 1'b1;
                    stn[u].issued <= 1'b0;
                    stn[u].idx    <= dispatch.idx;
                    stn[u].op     <= dispatch.instr.op;
                    stn[u].rd     <= dispatch.instr.rd;
                    stn[u].rs1    <= dispatch.instr.rs1;
                    stn[u].rs2    <= dispatch.instr.rs2;
                    stn[u].use2   <= dispatch.instr.op != OP_ADDI;
                    stn[u].imm    <= dispatch.instr.imm;
                    stn[u].t1     <= live_tag(rs1_tag, wb);
                    stn[u].t2     <= (dispatch.instr.op == OP_ADDI) ? FU_NONE
                                                                   : live_tag(rs2_tag, wb);
                end
            end
            if (issue_go[1]) begin
                mul_timer <= TW'(`SB_MUL_CYCLES - 1);
            end else if (mul_timer != '0) begin
                mul_timer <= mul_timer - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/reg_state.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sb_cfg.svh"

module reg_state
    import isa_pkg::*, sb_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  instr_t    head_instr,
    input  dispatch_t dispatch,
    input  wb_t       wb,
    input  reg_idx_t  rd1_idx,
    input  reg_idx_t  rd2_idx,
    output fu_tag_e   rs1_tag,
    output fu_tag_e   rs2_tag,
    output fu_tag_e   rd_pending,
    output word_t     rdata1,
    output word_t     rdata2
);

    fu_tag_e status [`SB_NREG];
    word_t   rf [`SB_NREG];

    assign rs1_tag    = status[head_instr.rs1];
    assign rs2_tag    = status[head_instr.rs2];
    assign rd_pending = status[head_instr.rd];

    assign rdata1 = rf[rd1_idx];
    assign rdata2 = rf[rd2_idx];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < `SB_NREG; i++) begin
                status[i] <= FU_NONE;
                rf[i]     <= '0;
            end
        end else begin
            // clear only if no younger writer took the register over
            if (wb.valid && status[wb.rd] == wb.tag) begin
                status[wb.rd] <= FU_NONE;
            end
            if (wb.valid && wb.rd != '0) begin
                rf[wb.rd] <= wb.data;
            end
            // r0 is never marked, so readers of r0 never wait
            if (dispatch.valid && dispatch.instr.rd != '0) begin
                status[dispatch.instr.rd] <= unit_tag(fu_of(dispatch.instr.op));
            end
        end
    end

endmodule

`default_nettype wire

/* logic/stage_tracker.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sb_cfg.svh"

module stage_tracker
    import isa_pkg::*, sb_pkg::*;
(
    input  logic         clk,
    input  logic         resetn,
    input  logic         accept,
    input  entry_idx_t   wptr,
    input  entry_idx_t   dptr,
    input  entry_idx_t   rptr,
    input  instr_t       head_instr,
    input  logic [1:0]   fu_busy,
    input  fu_tag_e      rd_pending,
    input  issue_t [1:0] issue_entry,
    input  wb_t          wb,
    output dispatch_t    dispatch,
    output logic         retire
);

    stage_e st [`SB_DEPTH];
    logic   head_unit;

    assign head_unit = fu_of(head_instr.op);

    // WAW: no dispatch while another writer of rd is in flight
    always_comb begin
        dispatch.valid = st[dptr] == ST_WAITING && !fu_busy[head_unit] &&
                         (head_instr.rd == '0 || rd_pending == FU_NONE);
        dispatch.idx   = dptr;
        dispatch.instr = head_instr;
    end

    assign retire = st[rptr] == ST_DONE;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < `SB_DEPTH; i++) begin
                st[i] <= ST_EMPTY;
            end
        end else begin
            if (accept) begin
                st[wptr] <= ST_WAITING;
            end
            if (dispatch.valid) begin
                st[dptr] <= ST_DISPATCHED;
            end
            for (int u = 0; u < 2; u++) begin
                if (issue_entry[u].valid) begin
                    st[issue_entry[u].idx] <= ST_ISSUED;
                end
            end
            if (wb.valid) begin
                st[wb.idx] <= ST_DONE;
            end
            // the window is never full, so wptr and rptr do not meet here
            if (retire) begin
                st[rptr] <= ST_EMPTY;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/window_ptrs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "sb_cfg.svh"

module window_ptrs
    import sb_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       in_valid,
    input  logic       dispatch_fire,
    input  logic       retire_fire,
    output logic       accept,
    output entry_idx_t wptr,
    output entry_idx_t dptr,
    output entry_idx_t rptr,
    output logic       stall
);

    localparam int CW = $clog2(`SB_DEPTH + 1);

    logic [CW-1:0] count;
    logic [CW-1:0] count_next;

    assign accept = in_valid && !stall;

    // entries held between accept and retire
    assign count_next = count + CW'(accept) - CW'(retire_fire);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wptr  <= '0;
            dptr  <= '0;
            rptr  <= '0;
            count <= '0;
            stall <= 1'b0;
        end else begin
            if (accept) begin
                wptr <= wptr + 1'b1;
            end
            if (dispatch_fire) begin
                dptr <= dptr + 1'b1;
            end
            if (retire_fire) begin
                rptr <= rptr + 1'b1;
            end
            count <= count_next;
            stall <= count_next >= CW'(`SB_STALL_AT);
        end
    end

endmodule

`default_nettype wire

/* logic/sb_pkg.sv */
`default_nettype none
`include "sb_cfg.svh"

package sb_pkg;
    import isa_pkg::*;

    typedef logic [$clog2(`SB_DEPTH)-1:0] entry_idx_t;

    typedef enum logic [2:0] {
        ST_EMPTY,
        ST_WAITING,
        ST_DISPATCHED,
        ST_ISSUED,
        ST_DONE
    } stage_e;

    // pending-writer tag, also names the unit on the writeback bus
    typedef enum logic [1:0] {
        FU_NONE,
        FU_ALU,
        FU_MUL
    } fu_tag_e;

    typedef struct packed {
        logic valid;
        entry_idx_t idx;
        instr_t instr;
    } dispatch_t;

    typedef struct packed {
        logic valid;
        entry_idx_t idx;
    } issue_t;

    typedef struct packed {
        logic valid;
        fu_tag_e tag;
        entry_idx_t idx;
        reg_idx_t rd;
        word_t data;
    } wb_t;

    typedef struct packed {
        reg_idx_t rd;
        word_t data;
    } commit_t;

    function automatic fu_tag_e unit_tag(input logic unit);
        return unit ? FU_MUL : FU_ALU;
    endfunction

endpackage

`default_nettype wire

/* logic/isa_pkg.sv */
`default_nettype none
`include "sb_cfg.svh"

package isa_pkg;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_XOR,
        OP_ADDI,
        OP_MUL
    } op_e;

    typedef logic [$clog2(`SB_NREG)-1:0] reg_idx_t;
    typedef logic [`SB_XLEN-1:0] word_t;

    typedef struct packed {
        op_e op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic [`SB_IMM_W-1:0] imm;
    } instr_t;

    // unit select, 1 picks the multiplier station
    function automatic logic fu_of(input op_e op);
        return op == OP_MUL;
    endfunction

endpackage

`default_nettype wire

/* include/sb_cfg.svh */
`ifndef SB_CFG_SVH
`define SB_CFG_SVH

// instruction window entries, a power of two
`define SB_DEPTH 8

// architectural registers
`define SB_NREG 32

// data path width
`define SB_XLEN 32

// immediate field, sign-extended to SB_XLEN
`define SB_IMM_W 12

// multiplier latency from issue to writeback
`define SB_MUL_CYCLES 4

// occupancy at which input stall rises
`define SB_STALL_AT 6

`endif
